// ==== verilog/net_pkg.sv ====
/*
 * Network clock crossing package.
 * Stream widths, register chain length and FIFO geometry shared by the design.
 */
package net_pkg;

  // Stream payload width in bits.
  localparam int NET_DATA_BITS = 64;

  // One keep bit per payload byte.
  localparam int NET_KEEP_BITS = NET_DATA_BITS / 8;

  // Register slices on each side of a crossing.
  localparam int NET_N_STGS = 2;

  // Entries per crossing FIFO, a power of two.
  localparam int NET_FIFO_DEPTH = 16;

  // Pointer carries one wrap bit above the address.
  localparam int NET_PTR_BITS = $clog2(NET_FIFO_DEPTH) + 1;

endpackage

// ==== verilog/axis_if.sv ====
/*
 * AXI-stream link.
 * A beat moves on a rising edge where tvalid and tready are both high.
 */
interface axis_if #(
  parameter int DATA_BITS = net_pkg::NET_DATA_BITS,
  parameter int KEEP_BITS = net_pkg::NET_KEEP_BITS
) ();

  logic                 tvalid;
  logic                 tready;
  logic [DATA_BITS-1:0] tdata;
  logic [KEEP_BITS-1:0] tkeep;
  logic                 tlast;

  // Source side, holds valid and payload until the beat moves.
  modport m (output tvalid, output tdata, output tkeep, output tlast, input tready);

  // Sink side, only back-pressure flows upstream.
  modport s (input tvalid, input tdata, input tkeep, input tlast, output tready);

endinterface

// ==== verilog/axis_reg_stage.sv ====
/*
 * AXI-stream register slice.
 * Registers valid, payload and upstream tready, with a one-beat skid buffer.
 */
module axis_reg_stage (
  input logic nclk,
  input logic arst_n,
  axis_if.s   s,
  axis_if.m   m
);
  import net_pkg::*;

  logic                     out_valid;
  logic [NET_DATA_BITS:0]   out_pay;
  logic                     skid_valid;
  logic [NET_DATA_BITS:0]   skid_pay;
  logic [NET_KEEP_BITS-1:0] out_keep;
  logic [NET_KEEP_BITS-1:0] skid_keep;
  logic                     in_rdy;
  logic                     accept;
  logic                     out_free;

  // Beat taken from upstream this cycle.
  assign accept   = s.tvalid & in_rdy;
  // Output register empties or drains this cycle.
  assign out_free = ~out_valid | m.tready;

  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_rdy     <= 1'b0;
    end else if (out_free) begin
      // Skid entry goes first, upstream is stalled while it is held.
      out_valid  <= skid_valid | accept;
      skid_valid <= 1'b0;
      in_rdy     <= 1'b1;
    end else if (accept) begin
      // Output blocked, park the beat and drop tready next cycle.
      skid_valid <= 1'b1;
      in_rdy     <= 1'b0;
    end
  end

  // Payload path, no reset.
  always_ff @(posedge nclk) begin
    if (out_free && skid_valid) begin
      out_pay  <= skid_pay;
      out_keep <= skid_keep;
    end else if (out_free && accept) begin
      out_pay  <= {s.tlast, s.tdata};
      out_keep <= s.tkeep;
    end
    if (!out_free && accept) begin
      skid_pay  <= {s.tlast, s.tdata};
      skid_keep <= s.tkeep;
    end
  end

  assign s.tready = in_rdy;
  assign m.tvalid = out_valid;
  assign m.tdata  = out_pay[NET_DATA_BITS-1:0];
  assign m.tlast  = out_pay[NET_DATA_BITS];
  assign m.tkeep  = out_keep;

endmodule

// ==== verilog/axis_reg_array.sv ====
/*
 * Chain of AXI-stream register slices.
 * N_STAGES cycles of latency at one beat per cycle.
 */
module axis_reg_array #(
  parameter int N_STAGES = net_pkg::NET_N_STGS
) (
  input logic nclk,
  input logic arst_n,
  axis_if.s   s,
  axis_if.m   m
);
  import net_pkg::*;

  // Link i feeds stage i, the last link drains to m.
  axis_if #(.DATA_BITS(NET_DATA_BITS), .KEEP_BITS(NET_KEEP_BITS)) link [N_STAGES+1] ();

  // Chain input.
  assign link[0].tvalid = s.tvalid;
  assign link[0].tdata  = s.tdata;
  assign link[0].tkeep  = s.tkeep;
  assign link[0].tlast  = s.tlast;
  assign s.tready       = link[0].tready;

  for (genvar i = 0; i < N_STAGES; i++) begin : g_stage
    axis_reg_stage u_stage (
      .nclk   (nclk),
      .arst_n (arst_n),
      .s      (link[i]),
      .m      (link[i+1])
    );
  end

  // Chain output.
  assign m.tvalid                = link[N_STAGES].tvalid;
  assign m.tdata                 = link[N_STAGES].tdata;
  assign m.tkeep                 = link[N_STAGES].tkeep;
  assign m.tlast                 = link[N_STAGES].tlast;
  assign link[N_STAGES].tready   = m.tready;

endmodule

// ==== verilog/axis_async_fifo.sv ====
/*
 * Dual-clock AXI-stream FIFO.
 * Gray-coded pointers cross through two-flop synchronizers.
 * Full and empty flags are registered in their own domain.
 */
module axis_async_fifo (
  input logic wclk,
  input logic wrst_n,
  input logic rclk,
  input logic rrst_n,
  axis_if.s   s,
  axis_if.m   m
);
  import net_pkg::*;

  // Entry is {tlast, tkeep, tdata}.
  logic [NET_DATA_BITS+NET_KEEP_BITS:0] mem [NET_FIFO_DEPTH];

  logic [NET_PTR_BITS-1:0] wbin;
  logic [NET_PTR_BITS-1:0] wgray;
  logic [NET_PTR_BITS-1:0] wbin_next;
  logic [NET_PTR_BITS-1:0] wgray_next;
  logic [NET_PTR_BITS-1:0] rgray_w1;
  logic [NET_PTR_BITS-1:0] rgray_w2;
  logic                    full_r;
  logic                    wr_en;

  logic [NET_PTR_BITS-1:0] rbin;
  logic [NET_PTR_BITS-1:0] rgray;
  logic [NET_PTR_BITS-1:0] rbin_next;
  logic [NET_PTR_BITS-1:0] rgray_next;
  logic [NET_PTR_BITS-1:0] wgray_r1;
  logic [NET_PTR_BITS-1:0] wgray_r2;
  logic                    empty_r;
  logic                    rd_en;

  // Write domain.
  assign wr_en      = s.tvalid & ~full_r;
  assign wbin_next  = wbin + NET_PTR_BITS'(wr_en);
  assign wgray_next = wbin_next ^ (wbin_next >> 1);

  always_ff @(posedge wclk or negedge wrst_n) begin
    if (!wrst_n) begin
      wbin     <= '0;
      wgray    <= '0;
      rgray_w1 <= '0;
      rgray_w2 <= '0;
      // Held full in reset so no beat is taken.
      full_r   <= 1'b1;
    end else begin
      wbin     <= wbin_next;
      wgray    <= wgray_next;
      rgray_w1 <= rgray;
      rgray_w2 <= rgray_w1;
      // Full when the writer is one lap ahead of the reader.
      full_r   <= wgray_next == {~rgray_w2[NET_PTR_BITS-1 -: 2], rgray_w2[NET_PTR_BITS-3:0]};
    end
  end

  always_ff @(posedge wclk) begin
    if (wr_en) begin
      mem[wbin[NET_PTR_BITS-2:0]] <= {s.tlast, s.tkeep, s.tdata};
    end
  end

  assign s.tready = ~full_r;

  // Read domain.
  assign rd_en      = m.tready & ~empty_r;
  assign rbin_next  = rbin + NET_PTR_BITS'(rd_en);
  assign rgray_next = rbin_next ^ (rbin_next >> 1);

  always_ff @(posedge rclk or negedge rrst_n) begin
    if (!rrst_n) begin
      rbin     <= '0;
      rgray    <= '0;
      wgray_r1 <= '0;
      wgray_r2 <= '0;
      empty_r  <= 1'b1;
    end else begin
      rbin     <= rbin_next;
      rgray    <= rgray_next;
      wgray_r1 <= wgray;
      wgray_r2 <= wgray_r1;
      // Empty when both pointers sit on the same entry and lap.
      empty_r  <= rgray_next == wgray_r2;
    end
  end

  // Head entry, stable until popped.
  assign m.tvalid = ~empty_r;
  assign {m.tlast, m.tkeep, m.tdata} = mem[rbin[NET_PTR_BITS-2:0]];

endmodule

// ==== verilog/network_ccross_early.sv ====
/*
 * Early network clock crossing.
 * Path A moves beats from the raw clock rclk to nclk, path B the other way.
 * Each side has a register chain, the crossing is a dual-clock FIFO.
 */
module network_ccross_early (
  input logic rclk,
  input logic nclk,
  input logic arst_n,
  // Raw network clock side.
  axis_if.s   s_axis_rclk,
  axis_if.m   m_axis_rclk,
  // Internal clock side.
  axis_if.s   s_axis_nclk,
  axis_if.m   m_axis_nclk
);
  import net_pkg::*;

  logic [1:0] rst_r_sync;
  logic [1:0] rst_n_sync;
  logic       rst_r_n;
  logic       rst_n_n;

  // Assert at once, release after two edges of the raw clock.
  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      rst_r_sync <= 2'b00;
    end else begin
      rst_r_sync <= {rst_r_sync[0], 1'b1};
    end
  end

  // Same release on the internal clock.
  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      rst_n_sync <= 2'b00;
    end else begin
      rst_n_sync <= {rst_n_sync[0], 1'b1};
    end
  end

  assign rst_r_n = rst_r_sync[1];
  assign rst_n_n = rst_n_sync[1];

  // Links between chains and FIFOs.
  axis_if #(.DATA_BITS(NET_DATA_BITS), .KEEP_BITS(NET_KEEP_BITS)) s_axis_rclk_int ();
  axis_if #(.DATA_BITS(NET_DATA_BITS), .KEEP_BITS(NET_KEEP_BITS)) m_axis_rclk_int ();
  axis_if #(.DATA_BITS(NET_DATA_BITS), .KEEP_BITS(NET_KEEP_BITS)) s_axis_nclk_int ();
  axis_if #(.DATA_BITS(NET_DATA_BITS), .KEEP_BITS(NET_KEEP_BITS)) m_axis_nclk_int ();

  // Path A, rclk into nclk.
  axis_reg_array #(.N_STAGES(NET_N_STGS)) u_arr_r_in (
    .nclk (rclk), .arst_n (rst_r_n), .s (s_axis_rclk), .m (s_axis_rclk_int)
  );

  axis_async_fifo u_fifo_r2n (
    .wclk (rclk), .wrst_n (rst_r_n), .rclk (nclk), .rrst_n (rst_n_n),
    .s    (s_axis_rclk_int), .m (m_axis_nclk_int)
  );

  axis_reg_array #(.N_STAGES(NET_N_STGS)) u_arr_n_out (
    .nclk (nclk), .arst_n (rst_n_n), .s (m_axis_nclk_int), .m (m_axis_nclk)
  );

  // Path B, nclk into rclk.
  axis_reg_array #(.N_STAGES(NET_N_STGS)) u_arr_n_in (
    .nclk (nclk), .arst_n (rst_n_n), .s (s_axis_nclk), .m (s_axis_nclk_int)
  );

  axis_async_fifo u_fifo_n2r (
    .wclk (nclk), .wrst_n (rst_n_n), .rclk (rclk), .rrst_n (rst_r_n),
    .s    (s_axis_nclk_int), .m (m_axis_rclk_int)
  );

  axis_reg_array #(.N_STAGES(NET_N_STGS)) u_arr_r_out (
    .nclk (rclk), .arst_n (rst_r_n), .s (m_axis_rclk_int), .m (m_axis_rclk)
  );

endmodule

// ==== verilog/net_ccross_top.sv ====
/*
 * Network clock crossing top level.
 * Maps plain AXI-stream ports onto the stream links of the crossing.
 */
module net_ccross_top (
  input  logic                             rclk,
  input  logic                             nclk,
  input  logic                             arst_n,
  // Path A input, raw clock.
  input  logic                             s_r_tvalid,
  output logic                             s_r_tready,
  input  logic [net_pkg::NET_DATA_BITS-1:0] s_r_tdata,
  input  logic [net_pkg::NET_KEEP_BITS-1:0] s_r_tkeep,
  input  logic                             s_r_tlast,
  // Path B input, internal clock.
  input  logic                             s_n_tvalid,
  output logic                             s_n_tready,
  input  logic [net_pkg::NET_DATA_BITS-1:0] s_n_tdata,
  input  logic [net_pkg::NET_KEEP_BITS-1:0] s_n_tkeep,
  input  logic                             s_n_tlast,
  // Path B output, raw clock.
  output logic                             m_r_tvalid,
  input  logic                             m_r_tready,
  output logic [net_pkg::NET_DATA_BITS-1:0] m_r_tdata,
  output logic [net_pkg::NET_KEEP_BITS-1:0] m_r_tkeep,
  output logic                             m_r_tlast,
  // Path A output, internal clock.
  output logic                             m_n_tvalid,
  input  logic                             m_n_tready,
  output logic [net_pkg::NET_DATA_BITS-1:0] m_n_tdata,
  output logic [net_pkg::NET_KEEP_BITS-1:0] m_n_tkeep,
  output logic                             m_n_tlast
);
  import net_pkg::*;

  axis_if #(.DATA_BITS(NET_DATA_BITS), .KEEP_BITS(NET_KEEP_BITS)) s_r_if ();
  axis_if #(.DATA_BITS(NET_DATA_BITS), .KEEP_BITS(NET_KEEP_BITS)) s_n_if ();
  axis_if #(.DATA_BITS(NET_DATA_BITS), .KEEP_BITS(NET_KEEP_BITS)) m_r_if ();
  axis_if #(.DATA_BITS(NET_DATA_BITS), .KEEP_BITS(NET_KEEP_BITS)) m_n_if ();

  // Inputs in.
  assign s_r_if.tvalid = s_r_tvalid;
  assign s_r_if.tdata  = s_r_tdata;
  assign s_r_if.tkeep  = s_r_tkeep;
  assign s_r_if.tlast  = s_r_tlast;
  assign s_r_tready    = s_r_if.tready;
  assign s_n_if.tvalid = s_n_tvalid;
  assign s_n_if.tdata  = s_n_tdata;
  assign s_n_if.tkeep  = s_n_tkeep;
  assign s_n_if.tlast  = s_n_tlast;
  assign s_n_tready    = s_n_if.tready;

  // Outputs out.
  assign m_r_tvalid    = m_r_if.tvalid;
  assign m_r_tdata     = m_r_if.tdata;
  assign m_r_tkeep     = m_r_if.tkeep;
  assign m_r_tlast     = m_r_if.tlast;
  assign m_r_if.tready = m_r_tready;
  assign m_n_tvalid    = m_n_if.tvalid;
  assign m_n_tdata     = m_n_if.tdata;
  assign m_n_tkeep     = m_n_if.tkeep;
  assign m_n_tlast     = m_n_if.tlast;
  assign m_n_if.tready = m_n_tready;

  network_ccross_early u_ccross (
    .rclk        (rclk),
    .nclk        (nclk),
    .arst_n      (arst_n),
    .s_axis_rclk (s_r_if),
    .m_axis_rclk (m_r_if),
    .s_axis_nclk (s_n_if),
    .m_axis_nclk (m_n_if)
  );

endmodule

// ==== test/net_ccross_asserts.sv ====
/*
 * Stream checker bound to the crossing top level.
 * Predicts each output beat from its index and checks the output handshake.
 */
module net_ccross_asserts (
  input logic                              rclk,
  input logic                              nclk,
  input logic                              arst_n,
  input logic                              s_r_tvalid,
  input logic                              s_r_tready,
  input logic                              s_n_tvalid,
  input logic                              s_n_tready,
  input logic                              m_n_tvalid,
  input logic                              m_n_tready,
  input logic [net_pkg::NET_DATA_BITS-1:0] m_n_tdata,
  input logic [net_pkg::NET_KEEP_BITS-1:0] m_n_tkeep,
  input logic                              m_n_tlast,
  input logic                              m_r_tvalid,
  input logic                              m_r_tready,
  input logic [net_pkg::NET_DATA_BITS-1:0] m_r_tdata,
  input logic [net_pkg::NET_KEEP_BITS-1:0] m_r_tkeep,
  input logic                              m_r_tlast
);
  timeunit 1ns;
  timeprecision 100ps;
  import net_pkg::*;

  // Accepted output beats, path A on nclk and path B on rclk.
  int unsigned cnt_a;
  int unsigned cnt_b;
  // Accepted input beats, path A on rclk and path B on nclk.
  int unsigned in_a;
  int unsigned in_b;

  // Low word is the index, high word its inverse.
  function automatic logic [NET_DATA_BITS-1:0] exp_data(int unsigned k);
    return {~k, k};
  endfunction

  // Every fourth beat closes a packet with four bytes.
  function automatic logic [NET_KEEP_BITS-1:0] exp_keep(int unsigned k);
    return (k % 4 == 3) ? 8'h0F : 8'hFF;
  endfunction

  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_a <= 0;
      in_b  <= 0;
    end else begin
      if (m_n_tvalid && m_n_tready) cnt_a <= cnt_a + 1;
      if (s_n_tvalid && s_n_tready) in_b <= in_b + 1;
    end
  end

  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_b <= 0;
      in_a  <= 0;
    end else begin
      if (m_r_tvalid && m_r_tready) cnt_b <= cnt_b + 1;
      if (s_r_tvalid && s_r_tready) in_a <= in_a + 1;
    end
  end

  // Path A payload.
  a_data_a: assert property (@(posedge nclk) disable iff (!arst_n)
    m_n_tvalid |-> m_n_tdata == exp_data(cnt_a))
    else $error("Mismatch m_n_tdata: got %h expected %h",
                $sampled(m_n_tdata), exp_data($sampled(cnt_a)));
  a_keep_a: assert property (@(posedge nclk) disable iff (!arst_n)
    m_n_tvalid |-> m_n_tkeep == exp_keep(cnt_a) && m_n_tlast == (cnt_a % 4 == 3))
    else $error("Mismatch m_n_tkeep/tlast: got %h/%h expected %h/%h",
                $sampled(m_n_tkeep), $sampled(m_n_tlast), exp_keep($sampled(cnt_a)),
                $sampled(cnt_a) % 4 == 3);

  // Path B payload.
  a_data_b: assert property (@(posedge rclk) disable iff (!arst_n)
    m_r_tvalid |-> m_r_tdata == exp_data(cnt_b))
    else $error("Mismatch m_r_tdata: got %h expected %h",
                $sampled(m_r_tdata), exp_data($sampled(cnt_b)));
  a_keep_b: assert property (@(posedge rclk) disable iff (!arst_n)
    m_r_tvalid |-> m_r_tkeep == exp_keep(cnt_b) && m_r_tlast == (cnt_b % 4 == 3))
    else $error("Mismatch m_r_tkeep/tlast: got %h/%h expected %h/%h",
                $sampled(m_r_tkeep), $sampled(m_r_tlast), exp_keep($sampled(cnt_b)),
                $sampled(cnt_b) % 4 == 3);

  // Stalled output holds until the handshake.
  a_hold_a: assert property (@(posedge nclk) disable iff (!arst_n)
    m_n_tvalid && !m_n_tready |=> m_n_tvalid && $stable({m_n_tlast, m_n_tkeep, m_n_tdata}))
    else $error("m_n output changed or dropped before its handshake");
  a_hold_b: assert property (@(posedge rclk) disable iff (!arst_n)
    m_r_tvalid && !m_r_tready |=> m_r_tvalid && $stable({m_r_tlast, m_r_tkeep, m_r_tdata}))
    else $error("m_r output changed or dropped before its handshake");

  // A full path drops its input tready, two beats per slice plus the FIFO.
  a_bp_a: assert property (@(posedge rclk) disable iff (!arst_n)
    in_a - cnt_a <= 4 * NET_N_STGS + NET_FIFO_DEPTH)
    else $error("Path A held more beats than it can store, s_r_tready did not fall");
  a_bp_b: assert property (@(posedge nclk) disable iff (!arst_n)
    in_b - cnt_b <= 4 * NET_N_STGS + NET_FIFO_DEPTH)
    else $error("Path B held more beats than it can store, s_n_tready did not fall");

  // No output before the first input beat, reset included.
  a_idle_a: assert property (@(posedge nclk) m_n_tvalid |-> in_a != 0)
    else $error("m_n_tvalid rose before any input beat was accepted");
  a_idle_b: assert property (@(posedge rclk) m_r_tvalid |-> in_b != 0)
    else $error("m_r_tvalid rose before any input beat was accepted");

endmodule

bind net_ccross_top net_ccross_asserts u_asserts (.*);

// ==== test/tb_net_ccross.sv ====
/*
 * Testbench for the network clock crossing.
 * Random traffic on both paths with output stalls, checked by the bound checker.
 */
module tb_net_ccross;
  timeunit 1ns;
  timeprecision 100ps;
  import net_pkg::*;

  localparam int  N_BEATS     = 400;
  localparam real NCLK_PERIOD = 10.0;
  localparam real RCLK_PERIOD = 6.2;

  logic                     rclk;
  logic                     nclk;
  logic                     arst_n;
  logic                     s_r_tvalid;
  logic                     s_r_tready;
  logic [NET_DATA_BITS-1:0] s_r_tdata;
  logic [NET_KEEP_BITS-1:0] s_r_tkeep;
  logic                     s_r_tlast;
  logic                     s_n_tvalid;
  logic                     s_n_tready;
  logic [NET_DATA_BITS-1:0] s_n_tdata;
  logic [NET_KEEP_BITS-1:0] s_n_tkeep;
  logic                     s_n_tlast;
  logic                     m_r_tvalid;
  logic                     m_r_tready;
  logic [NET_DATA_BITS-1:0] m_r_tdata;
  logic [NET_KEEP_BITS-1:0] m_r_tkeep;
  logic                     m_r_tlast;
  logic                     m_n_tvalid;
  logic                     m_n_tready;
  logic [NET_DATA_BITS-1:0] m_n_tdata;
  logic [NET_KEEP_BITS-1:0] m_n_tkeep;
  logic                     m_n_tlast;

  // Beats accepted at the inputs and delivered at the outputs.
  int unsigned sent_a = 0;
  int unsigned sent_b = 0;
  int unsigned recv_a = 0;
  int unsigned recv_b = 0;
  // Remaining cycles of a long output stall.
  int unsigned stall_a = 0;
  int unsigned stall_b = 0;

  net_ccross_top u_dut (.*);

  always #(NCLK_PERIOD / 2) nclk = ~nclk;
  always #(RCLK_PERIOD / 2) rclk = ~rclk;

  function automatic logic [NET_DATA_BITS-1:0] beat_data(int unsigned k);
    return {~k, k};
  endfunction

  function automatic logic [NET_KEEP_BITS-1:0] beat_keep(int unsigned k);
    return (k % 4 == 3) ? 8'h0F : 8'hFF;
  endfunction

  // Ready at 70 percent, now and then a stall long enough to fill the path.
  function automatic logic sink_ready(inout int unsigned stall);
    if (stall != 0) begin
      stall--;
      return 1'b0;
    end
    if ($urandom_range(149) == 0) begin
      stall = 80 + $urandom_range(40);
      return 1'b0;
    end
    return $urandom_range(99) < 70;
  endfunction

  // Path A source on the raw clock.
  always @(posedge rclk) begin
    if (s_r_tvalid && s_r_tready) sent_a++;
    // Payload may only change once the pending beat has moved.
    if (!s_r_tvalid || s_r_tready) begin
      if (arst_n && sent_a < N_BEATS && $urandom_range(99) < 60) begin
        s_r_tvalid <= 1'b1;
        s_r_tdata  <= beat_data(sent_a);
        s_r_tkeep  <= beat_keep(sent_a);
        s_r_tlast  <= (sent_a % 4 == 3);
      end else begin
        s_r_tvalid <= 1'b0;
      end
    end
  end

  // Path B source on the internal clock.
  always @(posedge nclk) begin
    if (s_n_tvalid && s_n_tready) sent_b++;
    if (!s_n_tvalid || s_n_tready) begin
      if (arst_n && sent_b < N_BEATS && $urandom_range(99) < 60) begin
        s_n_tvalid <= 1'b1;
        s_n_tdata  <= beat_data(sent_b);
        s_n_tkeep  <= beat_keep(sent_b);
        s_n_tlast  <= (sent_b % 4 == 3);
      end else begin
        s_n_tvalid <= 1'b0;
      end
    end
  end

  // Output sinks.
  always @(posedge nclk) begin
    if (m_n_tvalid && m_n_tready) recv_a++;
    m_n_tready <= sink_ready(stall_a);
  end

  always @(posedge rclk) begin
    if (m_r_tvalid && m_r_tready) recv_b++;
    m_r_tready <= sink_ready(stall_b);
  end

  // Watchdog, 40 nclk cycles per beat.
  initial begin
    #(N_BEATS * 40 * NCLK_PERIOD);
    $display("Timeout: not all beats were delivered, path A %0d, path B %0d", recv_a, recv_b);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(38));
    nclk       = 1'b0;
    rclk       = 1'b0;
    arst_n     = 1'b0;
    s_r_tvalid = 1'b0;
    s_r_tdata  = '0;
    s_r_tkeep  = '0;
    s_r_tlast  = 1'b0;
    s_n_tvalid = 1'b0;
    s_n_tdata  = '0;
    s_n_tkeep  = '0;
    s_n_tlast  = 1'b0;
    m_r_tready = 1'b0;
    m_n_tready = 1'b0;
    repeat (8) @(posedge nclk);
    arst_n <= 1'b1;
    wait (recv_a >= N_BEATS && recv_b >= N_BEATS);
    // Drain time to catch any extra beat.
    repeat (60) @(posedge nclk);
    if (recv_a != N_BEATS || recv_b != N_BEATS) begin
      $display("Mismatch beat count: path A %h path B %h expected %h", recv_a, recv_b, N_BEATS);
      $display("tests failed");
      $fatal(1, "output beat count wrong");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
verilog/net_pkg.sv
verilog/axis_if.sv
verilog/axis_reg_stage.sv
verilog/axis_reg_array.sv
verilog/axis_async_fifo.sv
verilog/network_ccross_early.sv
verilog/net_ccross_top.sv
test/net_ccross_asserts.sv
test/tb_net_ccross.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_net_ccross
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
